// ==== Makefile ====
TOP := rename_core_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, decide from sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f rename_core.f -o sim
	./obj_dir/sim | tee sim.log
	@if grep -qF '*** TEST PASSED ***' sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== hdl/issue_select.sv ====
// Issue selector draining the lowest busy reservation station slot through a valid/ready port
module issue_select #(
    parameter int RS_SLOTS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    busy [RS_SLOTS],
    input  rename_types::rs_entry_t entries [RS_SLOTS],
    output logic                    take [RS_SLOTS],
    output logic                    issue_valid,
    output rename_types::rs_entry_t issue_entry,
    input  logic                    issue_ready
);

    logic                    pick [RS_SLOTS];
    logic                    found;
    rename_types::rs_entry_t head_entry;
    logic                    skid_valid_q;
    rename_types::rs_entry_t skid_entry_q;

    // Lowest-numbered busy slot wins
    always_comb begin
        found      = 1'b0;
        head_entry = entries[0];
        for (int s = 0; s < RS_SLOTS; s++) begin
            pick[s] = busy[s] && !found;
            if (pick[s]) begin
                head_entry = entries[s];
            end
            found = found | busy[s];
        end
    end

    // Slot is released once the output stage owns its entry
    always_comb begin
        for (int s = 0; s < RS_SLOTS; s++) begin
            take[s] = pick[s] && !skid_valid_q;
        end
    end

    assign issue_valid = skid_valid_q || found;
    assign issue_entry = skid_valid_q ? skid_entry_q : head_entry;

    // Stalled entry parks in the skid so it cannot change under valid
    always_ff @(posedge clk) begin
        if (rst) begin
            skid_valid_q <= 1'b0;
        end else if (skid_valid_q) begin
            if (issue_ready) begin
                skid_valid_q <= 1'b0;
            end
        end else if (found && !issue_ready) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!skid_valid_q && found && !issue_ready) begin
            skid_entry_q <= head_entry;
        end
    end

endmodule

// ==== hdl/multi_fifo.sv ====
// Circular queue with several push and pop lanes, used for the instruction queue and free list
module multi_fifo #(
    parameter type T         = logic [7:0],
    parameter int  DEPTH     = 8,
    parameter int  PUSH_N    = 1,
    parameter int  POP_N     = 1,
    parameter bit  INIT_FULL = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     push_data [PUSH_N],
    input  logic pop,
    output T     pop_data [POP_N],
    output logic can_push,
    output logic can_pop
);

    // DEPTH is a power of two, pointers wrap on their own
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [PW-1:0] head_q;
    logic [PW-1:0] tail_q;
    logic [CW-1:0] count_q;
    logic          do_push;
    logic          do_pop;

    assign can_push = (DEPTH - int'(count_q)) >= PUSH_N;
    assign can_pop  = int'(count_q) >= POP_N;
    assign do_push  = push && can_push;
    assign do_pop   = pop && can_pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= INIT_FULL ? CW'(DEPTH) : CW'(0);
        end else begin
            if (do_push) begin
                tail_q <= tail_q + PW'(PUSH_N);
            end
            if (do_pop) begin
                head_q <= head_q + PW'(POP_N);
            end
            count_q <= count_q + (do_push ? CW'(PUSH_N) : CW'(0))
                               - (do_pop ? CW'(POP_N) : CW'(0));
        end
    end

    // Free list variant comes out of reset holding FIRST_FREE_TAG upward
    always_ff @(posedge clk) begin
        if (rst && INIT_FULL) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= T'(rename_types::FIRST_FREE_TAG + i);
            end
        end else if (do_push) begin
            for (int i = 0; i < PUSH_N; i++) begin
                mem[tail_q + PW'(i)] <= push_data[i];
            end
        end
    end

    // Registered read, valid the cycle after the pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            for (int i = 0; i < POP_N; i++) begin
                pop_data[i] <= mem[head_q + PW'(i)];
            end
        end
    end

endmodule

// ==== hdl/rat.sv ====
// Register alias table mapping architectural registers to physical tags
module rat #(
    parameter int SS = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  rv32i_types::arch_reg_t  rd_rs1 [SS],
    input  rv32i_types::arch_reg_t  rd_rs2 [SS],
    output rename_types::phys_tag_t map_rs1 [SS],
    output rename_types::phys_tag_t map_rs2 [SS],
    input  logic                    we [SS],
    input  rv32i_types::arch_reg_t  wr_rd [SS],
    input  rename_types::phys_tag_t wr_tag [SS]
);

    rename_types::phys_tag_t map_q [rv32i_types::ARCH_REGS];

    // Identity map after reset, x0 stays on tag 0 forever
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < rv32i_types::ARCH_REGS; r++) begin
                map_q[r] <= rename_types::phys_tag_t'(r);
            end
        end else begin
            // Later lanes overwrite earlier ones
            for (int i = 0; i < SS; i++) begin
                if (we[i] && wr_rd[i] != '0) begin
                    map_q[wr_rd[i]] <= wr_tag[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            map_rs1[i] = map_q[rd_rs1[i]];
            map_rs2[i] = map_q[rd_rs2[i]];
        end
    end

endmodule

// ==== hdl/rename_core.sv ====
// Top level of the two-wide rename and dispatch front, tying queues, RAT and issue logic together
module rename_core #(
    parameter int SS       = 2,
    parameter int IQ_DEPTH = 8,
    parameter int RS_SLOTS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  rv32i_types::inst_info_t in_inst [SS],
    input  logic                    free_valid,
    input  rename_types::phys_tag_t free_tag,
    output logic                    issue_valid,
    input  logic                    issue_ready,
    output rename_types::rs_entry_t issue_entry
);

    localparam int FL_DEPTH = rename_types::PHYS_REGS - rename_types::FIRST_FREE_TAG;

    logic                    iq_pop;
    logic                    iq_can_pop;
    logic                    fl_pop;
    logic                    fl_can_pop;
    rv32i_types::inst_info_t inst_group [SS];
    rename_types::phys_tag_t free_tags [SS];
    rename_types::phys_tag_t fl_push_data [1];
    rv32i_types::arch_reg_t  rat_rs1 [SS];
    rv32i_types::arch_reg_t  rat_rs2 [SS];
    rename_types::phys_tag_t rat_map_rs1 [SS];
    rename_types::phys_tag_t rat_map_rs2 [SS];
    logic                    rat_we [SS];
    rv32i_types::arch_reg_t  rat_rd [SS];
    rename_types::phys_tag_t rat_tag [SS];
    logic                    take [RS_SLOTS];
    rename_types::rs_entry_t slot_entry [RS_SLOTS];

    assign fl_push_data[0] = free_tag;

    rs_alloc_if #(.SS(SS), .RS_SLOTS(RS_SLOTS)) alloc0 ();

    // Instruction queue, one group in and one group out
    multi_fifo #(
        .T(rv32i_types::inst_info_t), .DEPTH(IQ_DEPTH), .PUSH_N(SS), .POP_N(SS)
    ) iq0 (
        .clk(clk), .rst(rst),
        .push(in_valid), .push_data(in_inst),
        .pop(iq_pop), .pop_data(inst_group),
        .can_push(in_ready), .can_pop(iq_can_pop)
    );

    // Free list, tags come back one at a time
    multi_fifo #(
        .T(rename_types::phys_tag_t), .DEPTH(FL_DEPTH), .PUSH_N(1), .POP_N(SS),
        .INIT_FULL(1'b1)
    ) fl0 (
        .clk(clk), .rst(rst),
        .push(free_valid), .push_data(fl_push_data),
        .pop(fl_pop), .pop_data(free_tags),
        .can_push(), .can_pop(fl_can_pop)
    );

    rat #(.SS(SS)) rat0 (
        .clk(clk), .rst(rst),
        .rd_rs1(rat_rs1), .rd_rs2(rat_rs2),
        .map_rs1(rat_map_rs1), .map_rs2(rat_map_rs2),
        .we(rat_we), .wr_rd(rat_rd), .wr_tag(rat_tag)
    );

    rename_dispatch #(.SS(SS), .RS_SLOTS(RS_SLOTS)) dispatch0 (
        .clk(clk), .rst(rst),
        .iq_can_pop(iq_can_pop), .fl_can_pop(fl_can_pop),
        .iq_pop(iq_pop), .fl_pop(fl_pop),
        .instruction(inst_group), .free_tags(free_tags),
        .rat_rs1(rat_rs1), .rat_rs2(rat_rs2),
        .rat_map_rs1(rat_map_rs1), .rat_map_rs2(rat_map_rs2),
        .rat_we(rat_we), .rat_rd(rat_rd), .rat_tag(rat_tag),
        .rs(alloc0)
    );

    for (genvar g = 0; g < RS_SLOTS; g++) begin : g_slot
        rs_slot #(.SS(SS), .SLOT(g)) slot0 (
            .clk(clk), .rst(rst), .rs(alloc0),
            .take(take[g]), .entry(slot_entry[g])
        );
    end

    issue_select #(.RS_SLOTS(RS_SLOTS)) select0 (
        .clk(clk), .rst(rst),
        .busy(alloc0.busy), .entries(slot_entry), .take(take),
        .issue_valid(issue_valid), .issue_entry(issue_entry), .issue_ready(issue_ready)
    );

endmodule

// ==== hdl/rename_dispatch.sv ====
// Rename and dispatch stage: pops a group, renames it and allocates reservation station slots
module rename_dispatch #(
    parameter int SS       = 2,
    parameter int RS_SLOTS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    iq_can_pop,
    input  logic                    fl_can_pop,
    output logic                    iq_pop,
    output logic                    fl_pop,
    input  rv32i_types::inst_info_t instruction [SS],
    input  rename_types::phys_tag_t free_tags [SS],
    output rv32i_types::arch_reg_t  rat_rs1 [SS],
    output rv32i_types::arch_reg_t  rat_rs2 [SS],
    input  rename_types::phys_tag_t rat_map_rs1 [SS],
    input  rename_types::phys_tag_t rat_map_rs2 [SS],
    output logic                    rat_we [SS],
    output rv32i_types::arch_reg_t  rat_rd [SS],
    output rename_types::phys_tag_t rat_tag [SS],
    rs_alloc_if.dispatch            rs
);

    localparam int FS_W = $clog2(RS_SLOTS + 1);

    logic                 avail_q;
    rename_types::order_t order_q;
    logic [FS_W-1:0]      free_slots;
    logic                 go;

    always_comb begin
        free_slots = '0;
        for (int s = 0; s < RS_SLOTS; s++) begin
            if (!rs.busy[s]) begin
                free_slots = free_slots + FS_W'(1);
            end
        end
    end

    // Room for this group plus the one that may still be in rename
    assign go     = iq_can_pop && fl_can_pop && (int'(free_slots) >= 2 * SS);
    assign iq_pop = go;
    assign fl_pop = go;

    // Popped data shows up one cycle after the pop
    always_ff @(posedge clk) begin
        if (rst) begin
            avail_q <= 1'b0;
            order_q <= '0;
        end else begin
            avail_q <= go;
            if (avail_q) begin
                order_q <= order_q + rename_types::order_t'(SS);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            rat_rs1[i] = instruction[i].rs1_s;
            rat_rs2[i] = instruction[i].rs2_s;
            rat_we[i]  = avail_q;
            rat_rd[i]  = instruction[i].rd_s;
            rat_tag[i] = free_tags[i];
        end
    end

    // RAT tag unless an earlier lane of the group writes the same register
    // x0 never matches, and the RAT keeps it on tag 0
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            rs.entries[i].inst    = instruction[i];
            rs.entries[i].rat.rs1 = rat_map_rs1[i];
            rs.entries[i].rat.rs2 = rat_map_rs2[i];
            rs.entries[i].rat.rd  = free_tags[i];
            rs.entries[i].order   = order_q + rename_types::order_t'(i);
            for (int j = 0; j < i; j++) begin
                if (instruction[j].rd_s != '0 && instruction[j].rd_s == instruction[i].rs1_s) begin
                    rs.entries[i].rat.rs1 = free_tags[j];
                end
                if (instruction[j].rd_s != '0 && instruction[j].rd_s == instruction[i].rs2_s) begin
                    rs.entries[i].rat.rs2 = free_tags[j];
                end
            end
        end
    end

    // Lanes in order onto the lowest free slots
    always_comb begin
        int lane;
        lane = 0;
        for (int s = 0; s < RS_SLOTS; s++) begin
            rs.write_en[s] = 1'b0;
            rs.lane_sel[s] = '0;
            if (avail_q && !rs.busy[s] && lane < SS) begin
                rs.write_en[s]       = 1'b1;
                rs.lane_sel[s][lane] = 1'b1;
                lane++;
            end
        end
    end

endmodule

// ==== hdl/rename_types.sv ====
// Renamed-side types: physical tags, order numbers and reservation station entries
package rename_types;

    // Size of the physical register file
    parameter int PHYS_REGS = 64;

    // Tags below this are the reset identity mapping of the RAT
    // Tags from here up start out in the free list
    parameter int FIRST_FREE_TAG = 32;

    // Physical register tag
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;

    // Program order number stamped at dispatch
    typedef logic [15:0] order_t;

    // Tags resolved for one instruction
    typedef struct packed {
        phys_tag_t rs1;
        phys_tag_t rs2;
        phys_tag_t rd;
    } rat_tags_t;

    // One reservation station entry
    typedef struct packed {
        rv32i_types::inst_info_t inst;
        rat_tags_t               rat;
        order_t                  order;
    } rs_entry_t;

endpackage

// ==== hdl/rs_alloc_if.sv ====
// Allocation path from rename/dispatch into the reservation station slot array
interface rs_alloc_if #(
    parameter int SS       = 2,
    parameter int RS_SLOTS = 8
);

    // One bit per slot, driven by the slot itself
    logic busy [RS_SLOTS];

    // Slot loads at the next edge
    logic write_en [RS_SLOTS];

    // One-hot lane choice per slot
    logic [SS-1:0] lane_sel [RS_SLOTS];

    // Renamed group of the current cycle
    rename_types::rs_entry_t entries [SS];

    modport dispatch (input busy, output write_en, output lane_sel, output entries);

    modport slot (output busy, input write_en, input lane_sel, input entries);

endinterface

// ==== hdl/rs_slot.sv ====
// One reservation station slot holding a renamed entry until the issue selector takes it
module rs_slot #(
    parameter int SS   = 2,
    parameter int SLOT = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    rs_alloc_if.slot                rs,
    input  logic                    take,
    output rename_types::rs_entry_t entry
);

    logic                    busy_q;
    rename_types::rs_entry_t entry_d;

    // Lane chosen for this slot by dispatch
    always_comb begin
        entry_d = rs.entries[0];
        for (int i = 0; i < SS; i++) begin
            if (rs.lane_sel[SLOT][i]) begin
                entry_d = rs.entries[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (rs.write_en[SLOT]) begin
            busy_q <= 1'b1;
        end else if (take) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rs.write_en[SLOT]) begin
            entry <= entry_d;
        end
    end

    assign rs.busy[SLOT] = busy_q;

endmodule

// ==== hdl/rv32i_types.sv ====
// Architectural-side types for the rename front, shared by queue, RAT and dispatch logic
package rv32i_types;

    // Number of architectural integer registers
    parameter int ARCH_REGS = 32;

    // Register index x0..x31
    typedef logic [4:0] arch_reg_t;

    // One decoded instruction as handed over by decode
    // Only the fields the rename front and the RVFI trace need are kept
    typedef struct packed {
        // Slot holds a real instruction
        logic        valid;

        // Program counter of this instruction and of its successor
        logic [31:0] pc_curr;
        logic [31:0] pc_next;

        // Raw instruction word
        logic [31:0] inst;

        // Source and destination register addresses
        arch_reg_t   rs1_s;
        arch_reg_t   rs2_s;
        arch_reg_t   rd_s;
    } inst_info_t;

endpackage

// ==== rename_core.f ====
hdl/rv32i_types.sv
hdl/rename_types.sv
hdl/rs_alloc_if.sv
hdl/multi_fifo.sv
hdl/rat.sv
hdl/rename_dispatch.sv
hdl/rs_slot.sv
hdl/issue_select.sv
hdl/rename_core.sv
tests/rename_core_tb.sv

// ==== tests/rename_core_tb.sv ====
// Testbench for rename_core, applies a table of instruction groups and checks every issued entry
module rename_core_tb;

    localparam int SS       = 2;
    localparam int N_ROWS   = 8;
    localparam int MAX_INST = 128;
    localparam int TIMEOUT  = 500;
    localparam int STRETCH  = 12;
    localparam int FL_TAGS  = rename_types::PHYS_REGS - rename_types::FIRST_FREE_TAG;
    localparam logic [31:0] BASE_PC = 32'h0000_1000;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    in_valid;
    logic                    in_ready;
    rv32i_types::inst_info_t in_inst [SS];
    logic                    free_valid;
    rename_types::phys_tag_t free_tag;
    logic                    issue_valid;
    logic                    issue_ready;
    rename_types::rs_entry_t issue_entry;

    // Per row: rs1, rs2, rd of lane 0, then of lane 1
    int unsigned row_regs [N_ROWS][6];
    // Row stalls the issue port for a stretch after it is accepted
    bit          row_hold [N_ROWS];

    // Reference rename state, indexed by order number where it is per instruction
    rename_types::phys_tag_t ref_map [32];
    rename_types::phys_tag_t ref_free [$];
    int                      pending [$];
    rename_types::rat_tags_t exp_tags [MAX_INST];
    rv32i_types::inst_info_t exp_inst [MAX_INST];
    bit                      seen [MAX_INST];

    int pushed;
    int predicted;
    int issued;
    int groups;
    int cycle;
    int hold_until;
    bit hold_issue;
    int checks;
    int check_errors;
    int main_errors;
    int tests;

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    rename_core #(.SS(SS), .IQ_DEPTH(8), .RS_SLOTS(8)) dut0 (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_inst(in_inst),
        .free_valid(free_valid), .free_tag(free_tag),
        .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_entry(issue_entry)
    );

    task automatic check_tags(input string name, input rename_types::rat_tags_t got,
                              input rename_types::rat_tags_t exp);
        checks++;
        if (got !== exp) begin
            check_errors++;
            $display("[ERROR] %0t %s (rs1/rs2/rd) got %0d/%0d/%0d expected %0d/%0d/%0d",
                     $time, name, got.rs1, got.rs2, got.rd, exp.rs1, exp.rs2, exp.rd);
        end
    endtask

    task automatic check_order(input string name, input rename_types::order_t got,
                               input rename_types::order_t exp);
        checks++;
        if (got !== exp) begin
            check_errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_inst(input string name, input rv32i_types::inst_info_t got,
                              input rv32i_types::inst_info_t exp);
        checks++;
        if (got !== exp) begin
            check_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Program order follows from the pc, so entries are matched whatever order they issue in
    task automatic record_issue(input rename_types::rs_entry_t e);
        int idx;
        idx = int'((e.inst.pc_curr - BASE_PC) >> 2);
        issued++;
        if ($isunknown(e.inst.pc_curr) || idx >= predicted) begin
            check_errors++;
            $display("Issued entry with pc %h matches no renamed instruction", e.inst.pc_curr);
        end else if (seen[idx]) begin
            check_errors++;
            $display("Instruction with order %0d issued more than once", idx);
        end else begin
            seen[idx] = 1'b1;
            check_order("issue_entry.order", e.order, rename_types::order_t'(idx));
            check_tags("issue_entry.rat", e.rat, exp_tags[idx]);
            check_inst("issue_entry.inst", e.inst, exp_inst[idx]);
        end
    endtask

    function automatic rv32i_types::inst_info_t make_inst(input int r, input int lane,
                                                          input int seq);
        rv32i_types::inst_info_t ii;
        ii.valid   = 1'b1;
        ii.pc_curr = BASE_PC + 32'(4 * seq);
        ii.pc_next = ii.pc_curr + 32'd4;
        ii.rs1_s   = 5'(row_regs[r][3 * lane]);
        ii.rs2_s   = 5'(row_regs[r][3 * lane + 1]);
        ii.rd_s    = 5'(row_regs[r][3 * lane + 2]);
        // R-type ADD, sequence number kept in funct7
        ii.inst    = {7'(seq), ii.rs2_s, ii.rs1_s, 3'b000, ii.rd_s, 7'b0110011};
        return ii;
    endfunction

    // Lanes one after another, each sees the mappings of the lanes before it
    task automatic rename_pending();
        int                      base;
        rv32i_types::inst_info_t ii;
        while (pending.size() > 0 && ref_free.size() >= SS) begin
            base = pending.pop_front();
            for (int lane = 0; lane < SS; lane++) begin
                ii = exp_inst[base + lane];
                exp_tags[base + lane].rs1 = ref_map[ii.rs1_s];
                exp_tags[base + lane].rs2 = ref_map[ii.rs2_s];
                exp_tags[base + lane].rd  = ref_free.pop_front();
                if (ii.rd_s != 5'd0) begin
                    ref_map[ii.rd_s] = exp_tags[base + lane].rd;
                end
            end
            predicted += SS;
        end
    endtask

    task automatic report_timeout(input string what);
        main_errors++;
        $display("Timed out waiting for %s at time %0t", what, $time);
    endtask

    task automatic push_group(input int r);
        int waited;
        waited = 0;
        for (int lane = 0; lane < SS; lane++) begin
            in_inst[lane] = make_inst(r, lane, pushed + lane);
        end
        in_valid = 1'b1;
        while (!in_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            in_valid = 1'b0;
            report_timeout("in_ready");
        end else begin
            @(negedge clk);
            in_valid = 1'b0;
            for (int lane = 0; lane < SS; lane++) begin
                exp_inst[pushed + lane] = in_inst[lane];
            end
            pending.push_back(pushed);
            pushed += SS;
            groups++;
            rename_pending();
            if (row_hold[r]) begin
                hold_until = cycle + STRETCH;
            end
        end
    endtask

    task automatic return_tag(input rename_types::phys_tag_t t);
        free_tag   = t;
        free_valid = 1'b1;
        @(negedge clk);
        free_valid = 1'b0;
        ref_free.push_back(t);
        rename_pending();
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (issued != predicted && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (issued != predicted) begin
            report_timeout("renamed entries to issue");
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %-16s %0d errors", name, check_errors + main_errors - err_before);
    endtask

    initial begin : issue_side
        void'($urandom(35720));
        issue_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (hold_issue || cycle < hold_until) begin
                issue_ready = 1'b0;
            end else begin
                // Ready about three cycles in four
                issue_ready = ($urandom % 4) != 0;
            end
            if (!rst && issue_valid === 1'b1 && issue_ready) begin
                record_issue(issue_entry);
            end
        end
    end

    initial begin : main
        int err_before;
        int guard;
        rst        = 1'b1;
        in_valid   = 1'b0;
        free_valid = 1'b0;
        free_tag   = '0;
        hold_issue = 1'b0;
        for (int lane = 0; lane < SS; lane++) begin
            in_inst[lane] = '0;
        end
        row_regs = '{'{1, 2, 5, 3, 0, 6}, '{5, 6, 7, 7, 5, 0}, '{8, 9, 8, 8, 8, 9},
                     '{0, 9, 10, 10, 10, 10}, '{10, 1, 11, 11, 10, 12},
                     '{12, 11, 1, 1, 0, 2}, '{2, 1, 3, 3, 2, 4}, '{4, 3, 5, 5, 5, 5}};
        row_hold = '{0, 0, 0, 0, 0, 1, 0, 0};
        for (int r = 0; r < 32; r++) begin
            ref_map[r] = rename_types::phys_tag_t'(r);
        end
        for (int t = rename_types::FIRST_FREE_TAG; t < rename_types::PHYS_REGS; t++) begin
            ref_free.push_back(rename_types::phys_tag_t'(t));
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        err_before = check_errors + main_errors;
        push_group(0);
        wait_drain();
        end_test("reset map", err_before);

        err_before = check_errors + main_errors;
        push_group(1);
        wait_drain();
        end_test("destination tags", err_before);

        err_before = check_errors + main_errors;
        push_group(2);
        push_group(3);
        wait_drain();
        end_test("group bypass", err_before);

        err_before = check_errors + main_errors;
        for (int r = 4; r < N_ROWS; r++) begin
            push_group(r);
        end
        wait_drain();
        end_test("order numbers", err_before);

        // Slots fill, then the instruction queue
        err_before = check_errors + main_errors;
        hold_issue = 1'b1;
        guard = 0;
        while (in_ready && guard < 16) begin
            push_group(groups % N_ROWS);
            guard++;
        end
        if (in_ready) begin
            main_errors++;
            $display("in_ready stayed high after %0d groups with issue_ready low", guard);
        end
        hold_issue = 1'b0;
        wait_drain();
        end_test("back-pressure", err_before);

        // Push until the model runs out of tags, the last group must stall in the queue
        err_before = check_errors + main_errors;
        guard = 0;
        while (pending.size() == 0 && guard < 24) begin
            push_group(groups % N_ROWS);
            guard++;
        end
        wait_drain();
        repeat (20) @(negedge clk);
        if (pending.size() == 0 || issued != FL_TAGS || issue_valid !== 1'b0) begin
            main_errors++;
            $display("Dispatch did not stop with the free list empty, %0d issued", issued);
        end
        // Returned out of numeric order
        return_tag(6'd45);
        return_tag(6'd33);
        return_tag(6'd40);
        return_tag(6'd38);
        push_group(groups % N_ROWS);
        wait_drain();
        end_test("free list", err_before);

        if (issued != pushed) begin
            main_errors++;
            $display("%0d instructions accepted but %0d issued", pushed, issued);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, check_errors + main_errors);
        if (check_errors + main_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
